// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////
    localparam int unsigned addr_width  = 32;    // program counter
    localparam int unsigned instr_width = 32;    // one instruction word

    ////////////////////////////////////////////////////////////////////
    // btb geometry
    ////////////////////////////////////////////////////////////////////
    localparam int unsigned btb_tag_width    = 7;  // tag bits kept per entry
    localparam int unsigned btb_offset_width = 2;  // byte offset inside a word, never indexed

    // index bits needed for a given entry count
    function automatic int unsigned btb_index_bits(input int unsigned entries);
        return (entries > 1) ? $clog2(entries) : 1;
    endfunction

    // sequencer states
    typedef enum logic [0:0] {
        fetch_idle = 1'b0,   // waiting for start
        fetch_run  = 1'b1    // issuing reads
    } fetch_state_e;

endpackage

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int unsigned imem_word_addr_width = 10;                         // word address
    localparam int unsigned imem_depth           = 1 << imem_word_addr_width;  // 1024 words

    // ram port opcodes
    typedef enum logic [0:0] {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_e;

    // who owns the ram port this cycle
    typedef enum logic [0:0] {
        req_loader = 1'b0,   // higher priority
        req_fetch  = 1'b1
    } requester_e;

endpackage

`default_nettype wire

// File: rtl/branch_target_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int unsigned btb_entries = 64
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic [fetch_pkg::addr_width-1:0] lookup_pc,
    output logic                                pred_taken,
    output logic [fetch_pkg::addr_width-1:0]      pred_target,
    input  wire logic                           resolve_valid,
    input  wire logic                           resolve_taken,
    input  wire logic [fetch_pkg::addr_width-1:0] resolve_pc,
    input  wire logic [fetch_pkg::addr_width-1:0] resolve_target
);
    import fetch_pkg::*;

    localparam int unsigned index_width = btb_index_bits(btb_entries);
    localparam int unsigned tag_lsb     = btb_offset_width + index_width;  // tag sits above index

    logic [btb_tag_width-1:0] tag_mem    [btb_entries];  // per-entry tag
    logic [addr_width-1:0]    target_mem [btb_entries];  // per-entry branch target
    logic [btb_entries-1:0]   valid_q;                   // entry holds a trained branch
    logic [btb_entries-1:0]   taken_q;                   // last resolution was taken

    logic [index_width-1:0]   lookup_idx;
    logic [btb_tag_width-1:0] lookup_tag;
    logic [index_width-1:0]   resolve_idx;
    logic [btb_tag_width-1:0] resolve_tag;

    assign lookup_idx  = lookup_pc[btb_offset_width +: index_width];
    assign lookup_tag  = lookup_pc[tag_lsb +: btb_tag_width];
    assign resolve_idx = resolve_pc[btb_offset_width +: index_width];
    assign resolve_tag = resolve_pc[tag_lsb +: btb_tag_width];

    ////////////////////////////////////////////////////////////////////
    // lookup, combinational so the next fetch is steered
    ////////////////////////////////////////////////////////////////////
    assign pred_taken  = valid_q[lookup_idx] && taken_q[lookup_idx]
                         && (tag_mem[lookup_idx] == lookup_tag);
    assign pred_target = target_mem[lookup_idx];  // only meaningful with pred_taken

    ////////////////////////////////////////////////////////////////////
    // training from the resolve stage
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            tag_mem[resolve_idx]    <= resolve_tag;     // overwrite whatever aliased here
            target_mem[resolve_idx] <= resolve_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            taken_q <= '0;
        end else if (resolve_valid) begin
            valid_q[resolve_idx] <= 1'b1;
            taken_q[resolve_idx] <= resolve_taken;      // not-taken clears it again
        end
    end

    // resolve stage hands back word addresses only
    resolve_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_valid |-> (resolve_pc[btb_offset_width-1:0] == '0));

endmodule

`default_nettype wire

// File: rtl/fetch_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_sequencer #(
    parameter int unsigned fetch_credits = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 start,
    input  wire logic                                 pred_taken,
    input  wire logic [fetch_pkg::addr_width-1:0]       pred_target,
    output logic [fetch_pkg::addr_width-1:0]            lookup_pc,
    input  wire logic                                 redirect_valid,
    input  wire logic [fetch_pkg::addr_width-1:0]       redirect_pc,
    output logic                                      req,
    output mem_pkg::mem_op_e                          op,
    output logic [mem_pkg::imem_word_addr_width-1:0]    addr,
    input  wire logic                                 gnt,
    input  wire logic [fetch_pkg::instr_width-1:0]      rdata,
    output logic                                      fetch_valid,
    output logic                                      fetch_pred_taken,
    output logic [fetch_pkg::addr_width-1:0]            fetch_pc,
    output logic [fetch_pkg::instr_width-1:0]           fetch_instr,
    input  wire logic                                 fetch_credit
);
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int unsigned credit_width = $clog2(fetch_credits + 1);

    fetch_state_e            state_q;
    logic [addr_width-1:0]   pc_q;
    logic [addr_width-1:0]   next_pc;
    logic [credit_width-1:0] credit_q;          // words decode can still take
    logic                    issue;             // read granted this cycle
    logic                    drop;              // in-flight word killed by redirect
    logic                    inflight_q;        // read answered by rdata now
    logic [addr_width-1:0]   inflight_pc_q;
    logic                    inflight_pred_q;

    ////////////////////////////////////////////////////////////////////
    // request and next pc
    ////////////////////////////////////////////////////////////////////
    assign lookup_pc = pc_q;                    // btb sees the pc being fetched
    assign req   = (state_q == fetch_run) && (credit_q != '0) && !redirect_valid;
    assign op    = mem_read;                    // fetch never writes
    assign addr  = pc_q[btb_offset_width +: imem_word_addr_width];
    assign issue = req && gnt;
    assign drop  = inflight_q && redirect_valid;

    always_comb begin
        if (redirect_valid)  next_pc = redirect_pc;   // mispredict wins
        else if (pred_taken) next_pc = pred_target;
        else                 next_pc = pc_q + addr_width'(4);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fetch_idle;
            pc_q    <= '0;
        end else if (state_q == fetch_idle) begin
            if (start) begin
                state_q <= fetch_run;
                pc_q    <= '0;                  // always boot from address 0
            end
        end else if (redirect_valid || issue) begin
            pc_q <= next_pc;                    // holds under back-pressure
        end
    end

    // issue consumes, decode returns, a dropped word gives its credit back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) credit_q <= credit_width'(fetch_credits);
        else credit_q <= credit_q + credit_width'(fetch_credit) + credit_width'(drop)
                         - credit_width'(issue);
    end

    ////////////////////////////////////////////////////////////////////
    // pair the issued pc with the ram answer
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight_q  <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            inflight_q  <= issue;
            fetch_valid <= inflight_q && !redirect_valid;  // squash wrong-path word
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_pc_q   <= pc_q;
            inflight_pred_q <= pred_taken;
        end
        if (inflight_q) begin
            fetch_pc         <= inflight_pc_q;
            fetch_pred_taken <= inflight_pred_q;
            fetch_instr      <= rdata;          // ram answers one cycle after issue
        end
    end

    credit_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        credit_q <= credit_width'(fetch_credits));

    // every delivered word went out two edges earlier
    valid_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |-> $past(issue, 2));

endmodule

`default_nettype wire

// File: rtl/program_loader.sv
`default_nettype none
`timescale 1ns/1ps

module program_loader #(
    parameter int unsigned loader_depth = 2
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 load_valid,
    input  wire logic [mem_pkg::imem_word_addr_width-1:0] load_addr,
    input  wire logic [fetch_pkg::instr_width-1:0]      load_data,
    output logic                                      load_credit,
    output logic                                      req,
    output mem_pkg::mem_op_e                          op,
    output logic [mem_pkg::imem_word_addr_width-1:0]    addr,
    output logic [fetch_pkg::instr_width-1:0]           wdata,
    input  wire logic                                 gnt
);
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int unsigned ptr_width   = (loader_depth > 1) ? $clog2(loader_depth) : 1;
    localparam int unsigned count_width = $clog2(loader_depth + 1);

    logic [imem_word_addr_width-1:0] addr_buf [loader_depth];
    logic [instr_width-1:0]          data_buf [loader_depth];
    logic [ptr_width-1:0]            wr_ptr_q;
    logic [ptr_width-1:0]            rd_ptr_q;
    logic [count_width-1:0]          count_q;
    logic                            pop;

    // wrap at loader_depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] p);
        return (p == ptr_width'(loader_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign req         = (count_q != '0);
    assign op          = mem_write;
    assign addr        = addr_buf[rd_ptr_q];
    assign wdata       = data_buf[rd_ptr_q];
    assign pop         = req && gnt;
    assign load_credit = pop;                   // slot freed, source may send again

    always_ff @(posedge clk) begin
        if (load_valid) begin
            addr_buf[wr_ptr_q] <= load_addr;
            data_buf[wr_ptr_q] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (load_valid) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop)        rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + count_width'(load_valid) - count_width'(pop);
        end
    end

    // source credit keeps it from pushing into a full buffer
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> (count_q < count_width'(loader_depth)));

endmodule

`default_nettype wire

// File: rtl/imem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module imem_arbiter (
    input  wire logic                                 loader_req,
    input  wire mem_pkg::mem_op_e                     loader_op,
    input  wire logic [mem_pkg::imem_word_addr_width-1:0] loader_addr,
    input  wire logic [fetch_pkg::instr_width-1:0]      loader_wdata,
    output logic                                      loader_gnt,
    input  wire logic                                 fetch_req,
    input  wire mem_pkg::mem_op_e                     fetch_op,
    input  wire logic [mem_pkg::imem_word_addr_width-1:0] fetch_addr,
    output logic                                      fetch_gnt,
    output logic                                      mem_en,
    output mem_pkg::mem_op_e                          mem_op,
    output logic [mem_pkg::imem_word_addr_width-1:0]    mem_addr,
    output logic [fetch_pkg::instr_width-1:0]           mem_wdata
);
    import mem_pkg::*;

    requester_e owner;   // steers the port mux

    assign owner      = loader_req ? req_loader : req_fetch;  // loader first
    assign loader_gnt = loader_req;
    assign fetch_gnt  = fetch_req && !loader_req;             // fetch waits, holds its request
    assign mem_en     = loader_req || fetch_req;

    always_comb begin
        if (owner == req_loader) begin
            mem_op    = loader_op;
            mem_addr  = loader_addr;
            mem_wdata = loader_wdata;
        end else begin
            mem_op    = fetch_op;
            mem_addr  = fetch_addr;
            mem_wdata = '0;                     // fetch only reads
        end
    end

    one_grant: assert final (!(loader_gnt && fetch_gnt));

endmodule

`default_nettype wire

// File: rtl/imem_ram.sv
`default_nettype none
`timescale 1ns/1ps

module imem_ram (
    input  wire logic                                 clk,
    input  wire logic                                 en,
    input  wire mem_pkg::mem_op_e                     op,
    input  wire logic [mem_pkg::imem_word_addr_width-1:0] addr,
    input  wire logic [fetch_pkg::instr_width-1:0]      wdata,
    output logic [fetch_pkg::instr_width-1:0]           rdata
);
    import fetch_pkg::*;
    import mem_pkg::*;

    logic [instr_width-1:0] mem_q [imem_depth];

    // one port, read data registered, a write leaves rdata alone
    always_ff @(posedge clk) begin
        if (en) begin
            if (op == mem_write) mem_q[addr] <= wdata;
            else                 rdata       <= mem_q[addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_top #(
    parameter int unsigned btb_entries   = 64,
    parameter int unsigned fetch_credits = 4,
    parameter int unsigned loader_depth  = 2
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 start,
    // decode side
    output logic                                      fetch_valid,
    output logic [fetch_pkg::addr_width-1:0]            fetch_pc,
    output logic [fetch_pkg::instr_width-1:0]           fetch_instr,
    output logic                                      fetch_pred_taken,
    input  wire logic                                 fetch_credit,
    // loader source
    input  wire logic                                 load_valid,
    input  wire logic [mem_pkg::imem_word_addr_width-1:0] load_addr,
    input  wire logic [fetch_pkg::instr_width-1:0]      load_data,
    output logic                                      load_credit,
    // branch resolution
    input  wire logic                                 resolve_valid,
    input  wire logic [fetch_pkg::addr_width-1:0]       resolve_pc,
    input  wire logic                                 resolve_taken,
    input  wire logic [fetch_pkg::addr_width-1:0]       resolve_target,
    input  wire logic                                 redirect_valid,
    input  wire logic [fetch_pkg::addr_width-1:0]       redirect_pc
);
    import fetch_pkg::*;
    import mem_pkg::*;

    logic [addr_width-1:0]           lookup_pc;
    logic                            pred_taken;
    logic [addr_width-1:0]           pred_target;
    logic                            fetch_req;
    mem_op_e                         fetch_op;
    logic [imem_word_addr_width-1:0] fetch_addr;
    logic                            fetch_gnt;
    logic                            loader_req;
    mem_op_e                         loader_op;
    logic [imem_word_addr_width-1:0] loader_addr;
    logic [instr_width-1:0]          loader_wdata;
    logic                            loader_gnt;
    logic                            mem_en;
    mem_op_e                         mem_op;
    logic [imem_word_addr_width-1:0] mem_addr;
    logic [instr_width-1:0]          mem_wdata;
    logic [instr_width-1:0]          mem_rdata;   // read data goes to fetch only

    branch_target_buffer #(
        .btb_entries (btb_entries)
    ) i_btb (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_pc      (lookup_pc),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .resolve_valid  (resolve_valid),
        .resolve_taken  (resolve_taken),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target)
    );

    fetch_sequencer #(
        .fetch_credits (fetch_credits)
    ) i_fetch_sequencer (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .pred_taken       (pred_taken),
        .pred_target      (pred_target),
        .lookup_pc        (lookup_pc),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .req              (fetch_req),
        .op               (fetch_op),
        .addr             (fetch_addr),
        .gnt              (fetch_gnt),
        .rdata            (mem_rdata),
        .fetch_valid      (fetch_valid),
        .fetch_pred_taken (fetch_pred_taken),
        .fetch_pc         (fetch_pc),
        .fetch_instr      (fetch_instr),
        .fetch_credit     (fetch_credit)
    );

    program_loader #(
        .loader_depth (loader_depth)
    ) i_program_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_credit (load_credit),
        .req         (loader_req),
        .op          (loader_op),
        .addr        (loader_addr),
        .wdata       (loader_wdata),
        .gnt         (loader_gnt)
    );

    imem_arbiter i_imem_arbiter (
        .loader_req   (loader_req),
        .loader_op    (loader_op),
        .loader_addr  (loader_addr),
        .loader_wdata (loader_wdata),
        .loader_gnt   (loader_gnt),
        .fetch_req    (fetch_req),
        .fetch_op     (fetch_op),
        .fetch_addr   (fetch_addr),
        .fetch_gnt    (fetch_gnt),
        .mem_en       (mem_en),
        .mem_op       (mem_op),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    imem_ram i_imem_ram (
        .clk   (clk),
        .en    (mem_en),
        .op    (mem_op),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: test/tb_fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int unsigned fetch_credits = 4;    // dut defaults
    localparam int unsigned loader_depth  = 2;
    localparam int unsigned btb_entries   = 64;
    localparam int unsigned btb_idx_bits  = $clog2(btb_entries);

    typedef enum logic [2:0] {
        act_load,       // a = first word addr, b = data generation, n = word count
        act_train,      // a = branch pc, b = target, n = taken
        act_start,
        act_redirect,   // a = new pc
        act_hold,       // decode stops returning credits, wait for drain
        act_release,
        act_run         // n = words to deliver
    } action_e;

    typedef struct packed {
        action_e     act;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] n;
    } table_entry_t;

    logic                            clk;
    logic                            rst_n;
    logic                            start;
    logic                            fetch_valid;
    logic [addr_width-1:0]           fetch_pc;
    logic [instr_width-1:0]          fetch_instr;
    logic                            fetch_pred_taken;
    logic                            fetch_credit;
    logic                            load_valid;
    logic [imem_word_addr_width-1:0] load_addr;
    logic [instr_width-1:0]          load_data;
    logic                            load_credit;
    logic                            resolve_valid;
    logic [addr_width-1:0]           resolve_pc;
    logic                            resolve_taken;
    logic [addr_width-1:0]           resolve_target;
    logic                            redirect_valid;
    logic [addr_width-1:0]           redirect_pc;

    ////////////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////////////
    logic [instr_width-1:0]   model_mem    [imem_depth];   // program as loaded
    bit                       model_valid  [btb_entries];
    bit                       model_taken  [btb_entries];
    logic [btb_tag_width-1:0] model_tag    [btb_entries];
    logic [addr_width-1:0]    model_target [btb_entries];
    logic [addr_width-1:0]    exp_pc;                       // next pc decode should see

    table_entry_t steps [$];
    integer       seed        = 32'h81b6_ac43;
    int           unreturned  = 0;      // words taken by decode, credit not yet sent back
    int           src_credits = loader_depth;
    bit           credit_pend = 1'b0;   // loader pulse seen, usable next cycle
    bit           holding     = 1'b0;
    int           delivered   = 0;
    int           cycle_count = 0;
    int           cycle_limit = 0;

    fetch_top i_fetch_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_instr      (fetch_instr),
        .fetch_pred_taken (fetch_pred_taken),
        .fetch_credit     (fetch_credit),
        .load_valid       (load_valid),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .load_credit      (load_credit),
        .resolve_valid    (resolve_valid),
        .resolve_pc       (resolve_pc),
        .resolve_taken    (resolve_taken),
        .resolve_target   (resolve_target),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;   // 10 ns period

    ////////////////////////////////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////////////////////////////////
    // program word, every address bit shows up in the data
    function automatic logic [31:0] fill_word(input logic [9:0] waddr, input logic [3:0] gen);
        return {gen, 6'h2a, ~waddr, 2'b01, waddr};
    endfunction

    function automatic logic [btb_idx_bits-1:0] btb_index(input logic [31:0] pc);
        return pc[2 +: btb_idx_bits];              // word offset is skipped
    endfunction

    function automatic logic [btb_tag_width-1:0] btb_tag(input logic [31:0] pc);
        return pc[2 + btb_idx_bits +: btb_tag_width];
    endfunction

    function automatic bit btb_hit(input logic [31:0] pc);
        logic [btb_idx_bits-1:0] idx;
        idx = btb_index(pc);
        return model_valid[idx] && model_taken[idx] && (model_tag[idx] == btb_tag(pc));
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic void add_step(input action_e act, input logic [31:0] a,
                                     input logic [31:0] b, input logic [15:0] n);
        table_entry_t e;
        e.act = act;
        e.a   = a;
        e.b   = b;
        e.n   = n;
        steps.push_back(e);
    endfunction

    ////////////////////////////////////////////////////////////////////
    // one clock: sample outputs, check, answer with credits
    ////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        requester_e owner_exp;
        bit         hit;
        @(posedge clk);
        #1;                                         // outputs settled, inputs change now
        src_credits += credit_pend;
        credit_pend  = load_credit;
        assert (src_credits <= loader_depth)
            else stop_run("loader returned more credits than words it was sent");

        // ram port: loader write first while words sit in its buffer
        owner_exp = (src_credits != loader_depth) ? req_loader : req_fetch;
        assert (load_credit === (owner_exp == req_loader))
            else stop_run($sformatf("Mismatch at %0t: load_credit %b, expected %b",
                                    $time, load_credit, owner_exp == req_loader));
        if (i_fetch_top.mem_en) begin
            assert ((owner_exp == req_loader)
                    ? (i_fetch_top.mem_op == mem_write && !i_fetch_top.fetch_gnt)
                    : (i_fetch_top.mem_op == mem_read && i_fetch_top.fetch_gnt))
                else stop_run("RAM port was given to the wrong requester");
        end

        if (fetch_valid) begin
            hit = btb_hit(exp_pc);
            assert (fetch_pc === exp_pc)
                else stop_run($sformatf("Mismatch at %0t: fetch_pc %h, expected %h",
                                        $time, fetch_pc, exp_pc));
            assert (fetch_instr === model_mem[exp_pc[2 +: imem_word_addr_width]])
                else stop_run($sformatf("Mismatch at %0t: instr %h at pc %h, expected %h",
                                        $time, fetch_instr, exp_pc,
                                        model_mem[exp_pc[2 +: imem_word_addr_width]]));
            assert (fetch_pred_taken === hit)
                else stop_run($sformatf("Mismatch at %0t: pred_taken %b at pc %h, expected %b",
                                        $time, fetch_pred_taken, exp_pc, hit));
            exp_pc = hit ? model_target[btb_index(exp_pc)] : exp_pc + 32'd4;  // next-pc rule
            delivered++;
            unreturned++;
            assert (unreturned <= fetch_credits)
                else stop_run("decode received more words than it had granted credits");
        end

        // decode consumes with random gaps
        if (!holding && unreturned > 0 && ($random(seed) & 3) != 0) begin
            fetch_credit = 1'b1;
            unreturned--;
        end else begin
            fetch_credit = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // table actions
    ////////////////////////////////////////////////////////////////////
    task automatic load_block(input logic [9:0] first, input logic [3:0] gen, input int count);
        logic [9:0] waddr;
        for (int k = 0; k < count; k++) begin
            waddr = first + 10'(k);
            while (src_credits == 0) next_cycle();   // source waits for a credit
            load_valid = 1'b1;
            load_addr  = waddr;
            load_data  = fill_word(waddr, gen);
            model_mem[waddr] = fill_word(waddr, gen);
            src_credits--;
            next_cycle();
            load_valid = 1'b0;
        end
        while (src_credits != loader_depth) next_cycle();  // all words in ram
    endtask

    task automatic train_branch(input logic [31:0] pc, input logic [31:0] target,
                                input logic taken);
        resolve_valid  = 1'b1;
        resolve_pc     = pc;
        resolve_target = target;
        resolve_taken  = taken;
        model_valid[btb_index(pc)]  = 1'b1;
        model_taken[btb_index(pc)]  = taken;
        model_tag[btb_index(pc)]    = btb_tag(pc);
        model_target[btb_index(pc)] = target;
        next_cycle();
        resolve_valid = 1'b0;
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        exp_pc         = pc;                       // word in flight gets dropped
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    // decode stops consuming, fetch must stall once the credits are used up
    task automatic hold_credits();
        holding = 1'b1;
        while (unreturned != fetch_credits) next_cycle();
        repeat (6) next_cycle();                   // nothing more may arrive
    endtask

    task automatic run_fetches(input int count);
        int target;
        target = delivered + count;
        while (delivered < target) next_cycle();
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("timeout: run not finished after %0d cycles", cycle_limit));
        end
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        table_entry_t e;
        int           total_fetches;
        rst_n          = 1'b0;
        start          = 1'b0;
        fetch_credit   = 1'b0;
        load_valid     = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        exp_pc         = '0;

        add_step(act_load,     32'h0,  32'h1,  16'd32);  // whole program, gen 1
        add_step(act_train,    32'h7c, 32'h0,  16'd1);   // wrap so fetch stays in program
        add_step(act_start,    32'h0,  32'h0,  16'd0);
        add_step(act_run,      32'h0,  32'h0,  16'd8);   // untrained, sequential
        add_step(act_hold,     32'h0,  32'h0,  16'd0);
        add_step(act_train,    32'h3c, 32'h20, 16'd1);   // loop 0x20..0x3c
        add_step(act_release,  32'h0,  32'h0,  16'd0);
        add_step(act_run,      32'h0,  32'h0,  16'd24);
        add_step(act_load,     32'h10, 32'h2,  16'd16);  // rewrite upper half while looping
        add_step(act_redirect, 32'h40, 32'h0,  16'd0);
        add_step(act_run,      32'h0,  32'h0,  16'd20);  // new words, then wrap to 0
        add_step(act_hold,     32'h0,  32'h0,  16'd0);
        add_step(act_train,    32'h3c, 32'h20, 16'd0);   // not taken again
        add_step(act_release,  32'h0,  32'h0,  16'd0);
        add_step(act_run,      32'h0,  32'h0,  16'd30);
        add_step(act_hold,     32'h0,  32'h0,  16'd0);
        add_step(act_release,  32'h0,  32'h0,  16'd0);
        add_step(act_run,      32'h0,  32'h0,  16'd4);   // resumes in order

        total_fetches = 0;
        foreach (steps[i]) begin
            if (steps[i].act == act_run) total_fetches += int'(steps[i].n);
        end
        cycle_limit = 20 * total_fetches + 200;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!fetch_valid && !load_credit)
            else stop_run("fetch or loader outputs active right after reset");

        foreach (steps[i]) begin
            e = steps[i];
            case (e.act)
                act_load:     load_block(e.a[9:0], e.b[3:0], int'(e.n));
                act_train:    train_branch(e.a, e.b, e.n[0]);
                act_start: begin
                    start  = 1'b1;                 // level, left high
                    exp_pc = '0;
                    next_cycle();
                end
                act_redirect: redirect_to(e.a);
                act_hold:     hold_credits();
                act_release:  holding = 1'b0;
                act_run:      run_fetches(int'(e.n));
                default:      stop_run("unknown action in stimulus table");
            endcase
        end

        repeat (4) next_cycle();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/fetch_pkg.sv
rtl/mem_pkg.sv
rtl/branch_target_buffer.sv
rtl/fetch_sequencer.sv
rtl/program_loader.sv
rtl/imem_arbiter.sv
rtl/imem_ram.sv
rtl/fetch_top.sv
test/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - rtl/fetch_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/branch_target_buffer.sv
  - rtl/fetch_sequencer.sv
  - rtl/program_loader.sv
  - rtl/imem_arbiter.sv
  - rtl/imem_ram.sv
  - rtl/fetch_top.sv
  - target: test
    files:
      - test/tb_fetch_top.sv
